//--- hw/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Global history predictor index split
`define BP_GHR_WIDTH 6
`define BP_GPC_WIDTH 4

// Local history predictor index split
`define BP_LHR_WIDTH 5
`define BP_LPC_WIDTH 3

// Meta predictor scores start in the middle of the 5-bit range
`define BP_SCORE_INIT 16

// Return stack holds 2**4 entries
`define BP_RAS_ADDR_WIDTH 4

`endif

//--- hw/bp_pkg.sv
package bp_pkg;

	// Upper bit set means taken
	typedef logic [1:0] sat_cnt_t;

	localparam sat_cnt_t SAT_CNT_INIT = 2'd1;

	typedef logic [4:0] score_t;

	typedef enum logic [1:0] {
		SEL_GLOBAL = 2'd0,
		SEL_LOCAL  = 2'd1,
		SEL_STATIC = 2'd2
	} predictor_sel_t;

	function automatic sat_cnt_t sat_cnt_next(sat_cnt_t cnt, logic taken);
		if (taken)
			return (cnt == 2'd3) ? cnt : cnt + 2'd1;
		return (cnt == 2'd0) ? cnt : cnt - 2'd1;
	endfunction

	function automatic score_t score_next(score_t score, logic hit);
		if (hit)
			return (score == '1) ? score : score + 5'd1;
		return (score == '0) ? score : score - 5'd1;
	endfunction

endpackage

//--- hw/branch_predictor.sv
`include "bp_defines.svh"

module branch_predictor
	import isa_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         predict_valid,
	input  logic [31:0]  predict_pc,
	input  branch_kind_t predict_kind,
	input  logic         predict_imm_sign,

	input  logic         resolve_valid,
	input  logic [31:0]  resolve_pc,
	input  branch_kind_t resolve_kind,
	input  logic         resolve_imm_sign,
	input  logic         resolve_taken,

	input  logic         jump_valid,
	input  logic         jump_is_jalr,
	input  logic [31:0]  jump_pc,
	input  reg_idx_t     jump_rd,
	input  reg_idx_t     jump_rs1,

	output logic         branch_pred_valid,
	output logic         branch_pred_taken,
	output logic         jalr_pred_valid,
	output logic [31:0]  jalr_pred_target
);

	logic global_taken;
	logic local_taken;
	logic global_resolve_pred;
	logic local_resolve_pred;

	history_predictor #(
		.NUM_HIST(1),
		.HR_WIDTH(`BP_GHR_WIDTH),
		.PC_WIDTH(`BP_GPC_WIDTH)
	) global_inst (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_pc(predict_pc),
		.lookup_kind(predict_kind),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_kind(resolve_kind),
		.resolve_taken(resolve_taken),
		.lookup_taken(global_taken),
		.resolve_pred(global_resolve_pred)
	);

	// One history register per branch kind
	history_predictor #(
		.NUM_HIST(NUM_BRANCH_KINDS),
		.HR_WIDTH(`BP_LHR_WIDTH),
		.PC_WIDTH(`BP_LPC_WIDTH)
	) local_inst (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_pc(predict_pc),
		.lookup_kind(predict_kind),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_kind(resolve_kind),
		.resolve_taken(resolve_taken),
		.lookup_taken(local_taken),
		.resolve_pred(local_resolve_pred)
	);

	meta_predictor meta_inst (
		.clk(clk),
		.rst_n(rst_n),
		.predict_valid(predict_valid),
		.predict_kind(predict_kind),
		.predict_imm_sign(predict_imm_sign),
		.global_taken(global_taken),
		.local_taken(local_taken),
		.resolve_valid(resolve_valid),
		.resolve_kind(resolve_kind),
		.resolve_imm_sign(resolve_imm_sign),
		.resolve_taken(resolve_taken),
		.global_resolve_pred(global_resolve_pred),
		.local_resolve_pred(local_resolve_pred),
		.branch_pred_valid(branch_pred_valid),
		.branch_pred_taken(branch_pred_taken)
	);

	ras #(
		.ADDR_WIDTH(`BP_RAS_ADDR_WIDTH)
	) ras_inst (
		.clk(clk),
		.rst_n(rst_n),
		.jump_valid(jump_valid),
		.jump_is_jalr(jump_is_jalr),
		.jump_pc(jump_pc),
		.jump_rd(jump_rd),
		.jump_rs1(jump_rs1),
		.jalr_pred_valid(jalr_pred_valid),
		.jalr_pred_target(jalr_pred_target)
	);

endmodule

//--- hw/history_predictor.sv
module history_predictor
	import isa_pkg::*;
	import bp_pkg::*;
#(
	parameter int NUM_HIST = 1,
	parameter int HR_WIDTH = 6,
	parameter int PC_WIDTH = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [31:0]  lookup_pc,
	input  branch_kind_t lookup_kind,
	input  logic         resolve_valid,
	input  logic [31:0]  resolve_pc,
	input  branch_kind_t resolve_kind,
	input  logic         resolve_taken,
	output logic         lookup_taken,
	output logic         resolve_pred
);

	localparam int IDX_WIDTH = HR_WIDTH + PC_WIDTH;
	localparam int DEPTH = 1 << IDX_WIDTH;

	logic [HR_WIDTH-1:0] hist [NUM_HIST];
	sat_cnt_t pht [DEPTH];

	logic [IDX_WIDTH-1:0] lookup_idx;
	logic [IDX_WIDTH-1:0] resolve_idx;
	int unsigned resolve_sel;

	// A single register is shared by all kinds
	function automatic int unsigned hist_sel(branch_kind_t kind);
		if (NUM_HIST == 1)
			return 0;
		return int'(kind);
	endfunction

	assign resolve_sel = hist_sel(resolve_kind);

	assign lookup_idx = {hist[hist_sel(lookup_kind)], lookup_pc[PC_WIDTH+1:2]};
	assign resolve_idx = {hist[resolve_sel], resolve_pc[PC_WIDTH+1:2]};

	assign lookup_taken = pht[lookup_idx][1];
	assign resolve_pred = pht[resolve_idx][1];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_HIST; i++)
				hist[i] <= '0;
			for (int j = 0; j < DEPTH; j++)
				pht[j] <= SAT_CNT_INIT;
		end
		else if (resolve_valid)
		begin
			pht[resolve_idx] <= sat_cnt_next(pht[resolve_idx], resolve_taken);
			// Newest outcome enters at bit 0
			hist[resolve_sel] <= {hist[resolve_sel][HR_WIDTH-2:0], resolve_taken};
		end
	end

endmodule

//--- hw/isa_pkg.sv
package isa_pkg;

	// Conditional branch kinds, funct3 order with gaps removed
	typedef enum logic [2:0] {
		BR_BEQ  = 3'd0,
		BR_BNE  = 3'd1,
		BR_BLT  = 3'd2,
		BR_BGE  = 3'd3,
		BR_BLTU = 3'd4,
		BR_BGEU = 3'd5
	} branch_kind_t;

	localparam int NUM_BRANCH_KINDS = 6;

	typedef logic [4:0] reg_idx_t;

	// Link register x1
	localparam reg_idx_t REG_RA = 5'd1;

endpackage

//--- hw/meta_predictor.sv
`include "bp_defines.svh"

module meta_predictor
	import isa_pkg::*;
	import bp_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         predict_valid,
	input  branch_kind_t predict_kind,
	input  logic         predict_imm_sign,
	input  logic         global_taken,
	input  logic         local_taken,
	input  logic         resolve_valid,
	input  branch_kind_t resolve_kind,
	input  logic         resolve_imm_sign,
	input  logic         resolve_taken,
	input  logic         global_resolve_pred,
	input  logic         local_resolve_pred,
	output logic         branch_pred_valid,
	output logic         branch_pred_taken
);

	score_t scores [NUM_BRANCH_KINDS][3];

	predictor_sel_t choice;
	logic pred_taken;
	logic resolve_preds [3];
	score_t global_score;
	score_t local_score;
	score_t static_score;

	assign global_score = scores[predict_kind][SEL_GLOBAL];
	assign local_score = scores[predict_kind][SEL_LOCAL];
	assign static_score = scores[predict_kind][SEL_STATIC];

	// Ties favour global, then local
	always_comb
	begin
		if (global_score >= local_score && global_score >= static_score)
			choice = SEL_GLOBAL;
		else if (local_score >= static_score)
			choice = SEL_LOCAL;
		else
			choice = SEL_STATIC;
	end

	always_comb
	begin
		case (choice)
			SEL_GLOBAL: pred_taken = global_taken;
			SEL_LOCAL:  pred_taken = local_taken;
			default:    pred_taken = predict_imm_sign;
		endcase
	end

	// Static guess is backward taken, i.e. the immediate sign
	always_comb
	begin
		resolve_preds[SEL_GLOBAL] = global_resolve_pred;
		resolve_preds[SEL_LOCAL] = local_resolve_pred;
		resolve_preds[SEL_STATIC] = resolve_imm_sign;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < NUM_BRANCH_KINDS; k++)
				for (int p = 0; p < 3; p++)
					scores[k][p] <= score_t'(`BP_SCORE_INIT);
		end
		else if (resolve_valid)
		begin
			for (int p = 0; p < 3; p++)
				scores[resolve_kind][p] <= score_next(scores[resolve_kind][p],
					resolve_preds[p] == resolve_taken);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			branch_pred_valid <= 1'b0;
		else
			branch_pred_valid <= predict_valid;
	end

	always_ff @(posedge clk)
	begin
		if (predict_valid)
			branch_pred_taken <= pred_taken;
	end

endmodule

//--- hw/ras.sv
module ras
	import isa_pkg::*;
#(
	parameter int ADDR_WIDTH = 4
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        jump_valid,
	input  logic        jump_is_jalr,
	input  logic [31:0] jump_pc,
	input  reg_idx_t    jump_rd,
	input  reg_idx_t    jump_rs1,
	output logic        jalr_pred_valid,
	output logic [31:0] jalr_pred_target
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [31:0] stack [DEPTH];
	logic [ADDR_WIDTH-1:0] top;
	logic [ADDR_WIDTH:0] count;

	logic push;
	logic pop;
	logic jalr_seen;
	logic empty;
	logic [ADDR_WIDTH-1:0] top_next;

	// Calls link through ra, returns jump back through it
	assign push = jump_valid && jump_rd == REG_RA;
	assign pop = jump_valid && jump_is_jalr && jump_rs1 == REG_RA && jump_rd != REG_RA;
	assign jalr_seen = jump_valid && jump_is_jalr;
	assign empty = count == '0;
	assign top_next = top + 1'b1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			top <= '0;
			count <= '0;
		end
		else if (push)
		begin
			// Wraps over the oldest entry once full
			top <= top_next;
			if (count != DEPTH[ADDR_WIDTH:0])
				count <= count + 1'b1;
		end
		else if (pop && !empty)
		begin
			top <= top - 1'b1;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			stack[top_next] <= jump_pc + 32'd4;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			jalr_pred_valid <= 1'b0;
		else
			jalr_pred_valid <= jalr_seen;
	end

	// Target uses the stack as it was before this cycle's push or pop
	always_ff @(posedge clk)
	begin
		if (jalr_seen)
			jalr_pred_target <= empty ? 32'd0 : stack[top];
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_branch_predictor -o tb_branch_predictor

# The simulation may stop with a fatal error, the log decides the verdict
./obj_dir/tb_branch_predictor > sim.log 2>&1 || true
cat sim.log

if grep -q "sim passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- tb.f
+incdir+hw
+incdir+verif
hw/isa_pkg.sv
hw/bp_pkg.sv
hw/history_predictor.sv
hw/meta_predictor.sv
hw/ras.sv
hw/branch_predictor.sv
verif/tb_branch_predictor.sv

//--- verif/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

localparam int GPC_W = `BP_GPC_WIDTH;
localparam int LPC_W = `BP_LPC_WIDTH;
localparam int RAS_DEPTH = 1 << `BP_RAS_ADDR_WIDTH;

int m_ghr;
int m_lhr [NUM_BRANCH_KINDS];
int m_gpht [1 << (`BP_GHR_WIDTH + GPC_W)];
int m_lpht [1 << (`BP_LHR_WIDTH + LPC_W)];
// Scores in global, local, static order
int m_score [NUM_BRANCH_KINDS][3];
logic [31:0] m_stack [$];

logic exp_bvalid;
logic exp_btaken;
logic exp_jvalid;
logic [31:0] exp_target;

function automatic int sat_step(int value, logic up, int max_value);
	if (up)
		return (value < max_value) ? value + 1 : value;
	return (value > 0) ? value - 1 : value;
endfunction

function automatic int shift_hist(int hist, logic taken, int width);
	return ((hist << 1) | int'(taken)) & ((1 << width) - 1);
endfunction

task automatic model_reset();
	m_ghr = 0;
	foreach (m_lhr[k])
		m_lhr[k] = 0;
	foreach (m_gpht[i])
		m_gpht[i] = 1;
	foreach (m_lpht[i])
		m_lpht[i] = 1;
	foreach (m_score[k, p])
		m_score[k][p] = `BP_SCORE_INIT;
	m_stack.delete();
	exp_bvalid = 1'b0;
	exp_jvalid = 1'b0;
endtask

task automatic model_step();
	int gi;
	int li;
	int best;
	logic guess [3];
	// Prediction sees the tables before this edge
	gi = (m_ghr << GPC_W) | int'(predict_pc[GPC_W+1:2]);
	li = (m_lhr[predict_kind] << LPC_W) | int'(predict_pc[LPC_W+1:2]);
	best = 0;
	for (int p = 1; p < 3; p++)
		if (m_score[predict_kind][p] > m_score[predict_kind][best])
			best = p;
	exp_bvalid = predict_valid;
	if (predict_valid)
	begin
		case (best)
			0: exp_btaken = m_gpht[gi] >= 2;
			1: exp_btaken = m_lpht[li] >= 2;
			default: exp_btaken = predict_imm_sign;
		endcase
	end
	if (resolve_valid)
	begin
		gi = (m_ghr << GPC_W) | int'(resolve_pc[GPC_W+1:2]);
		li = (m_lhr[resolve_kind] << LPC_W) | int'(resolve_pc[LPC_W+1:2]);
		guess[0] = m_gpht[gi] >= 2;
		guess[1] = m_lpht[li] >= 2;
		guess[2] = resolve_imm_sign;
		for (int p = 0; p < 3; p++)
			m_score[resolve_kind][p] = sat_step(m_score[resolve_kind][p],
				guess[p] == resolve_taken, 31);
		m_gpht[gi] = sat_step(m_gpht[gi], resolve_taken, 3);
		m_lpht[li] = sat_step(m_lpht[li], resolve_taken, 3);
		m_ghr = shift_hist(m_ghr, resolve_taken, `BP_GHR_WIDTH);
		m_lhr[resolve_kind] = shift_hist(m_lhr[resolve_kind], resolve_taken, `BP_LHR_WIDTH);
	end
	exp_jvalid = jump_valid && jump_is_jalr;
	if (exp_jvalid)
		exp_target = (m_stack.size() == 0) ? 32'd0 : m_stack[$];
	if (jump_valid && jump_rd == REG_RA)
	begin
		m_stack.push_back(jump_pc + 32'd4);
		// Oldest return address falls off
		if (m_stack.size() > RAS_DEPTH)
			void'(m_stack.pop_front());
	end
	else if (exp_jvalid && jump_rs1 == REG_RA && m_stack.size() > 0)
		void'(m_stack.pop_back());
endtask

`endif

//--- verif/tb_branch_predictor.sv
`include "bp_defines.svh"

module tb_branch_predictor
	import isa_pkg::*;
	import bp_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Reset, tests at their longest, final flush
	localparam int TEST_CYCLES = 10 + 24 + 27 + 2000 + 20 * 30 + 60 + 40 + 2;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

	logic clk;
	logic rst_n;
	logic predict_valid;
	logic [31:0] predict_pc;
	branch_kind_t predict_kind;
	logic predict_imm_sign;
	logic resolve_valid;
	logic [31:0] resolve_pc;
	branch_kind_t resolve_kind;
	logic resolve_imm_sign;
	logic resolve_taken;
	logic jump_valid;
	logic jump_is_jalr;
	logic [31:0] jump_pc;
	reg_idx_t jump_rd;
	reg_idx_t jump_rs1;
	logic branch_pred_valid;
	logic branch_pred_taken;
	logic jalr_pred_valid;
	logic [31:0] jalr_pred_target;

	string cur_test = "reset";
	int cycle_count = 0;
	logic [31:0] pc_pool [8];

	`include "bp_ref_model.svh"

	branch_predictor branch_predictor_inst (.*);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		if (!rst_n)
			model_reset();
		else
			model_step();
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_branch(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
			$display("sim failed");
			$fatal(1, "branch prediction mismatch");
		end
	endtask

	task automatic check_target(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "jalr target mismatch");
		end
	endtask

	task automatic check_valid(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
			$display("sim failed");
			$fatal(1, "valid strobe mismatch");
		end
	endtask

	task automatic compare_outputs();
		check_valid({cur_test, " branch valid"}, exp_bvalid, branch_pred_valid);
		if (exp_bvalid)
			check_branch(cur_test, exp_btaken, branch_pred_taken);
		check_valid({cur_test, " jalr valid"}, exp_jvalid, jalr_pred_valid);
		if (exp_jvalid)
			check_target(cur_test, exp_target, jalr_pred_target);
	endtask

	// Check last cycle's outputs on the falling edge and drop all strobes
	task automatic tick();
		@(negedge clk);
		compare_outputs();
		predict_valid = 1'b0;
		resolve_valid = 1'b0;
		jump_valid = 1'b0;
	endtask

	task automatic drive_predict(logic [31:0] pc, branch_kind_t kind, logic sign);
		predict_valid = 1'b1;
		predict_pc = pc;
		predict_kind = kind;
		predict_imm_sign = sign;
	endtask

	task automatic drive_resolve(logic [31:0] pc, branch_kind_t kind, logic sign, logic taken);
		resolve_valid = 1'b1;
		resolve_pc = pc;
		resolve_kind = kind;
		resolve_imm_sign = sign;
		resolve_taken = taken;
	endtask

	task automatic drive_jump(logic is_jalr, logic [31:0] pc, reg_idx_t rd, reg_idx_t rs1);
		jump_valid = 1'b1;
		jump_is_jalr = is_jalr;
		jump_pc = pc;
		jump_rd = rd;
		jump_rs1 = rs1;
	endtask

	function automatic branch_kind_t random_kind();
		return branch_kind_t'(3'($urandom_range(5)));
	endfunction

	function automatic logic [31:0] random_pc();
		return pc_pool[$urandom_range(7)];
	endfunction

	// Weakly not-taken counters and tied scores leave global in charge
	task automatic reset_predictions();
		cur_test = "reset_state";
		for (int i = 0; i < 12; i++)
		begin
			tick();
			drive_predict(random_pc(), random_kind(), 1'(i % 2));
			tick();
			check_branch(cur_test, 1'b0, branch_pred_taken);
		end
	endtask

	// Forward branch so that the static guess is always wrong
	task automatic learn_taken_loop();
		cur_test = "learning";
		repeat (24)
		begin
			tick();
			drive_resolve(pc_pool[0], BR_BNE, 1'b0, 1'b1);
		end
		tick();
		drive_predict(pc_pool[0], BR_BNE, 1'b0);
		tick();
		check_branch(cur_test, 1'b1, branch_pred_taken);
	endtask

	task automatic random_traffic();
		cur_test = "random_traffic";
		repeat (2000)
		begin
			tick();
			if (1'($urandom_range(1)))
				drive_predict(random_pc(), random_kind(), 1'($urandom_range(1)));
			if (1'($urandom_range(1)))
				drive_resolve(random_pc(), random_kind(), 1'($urandom_range(1)),
					$urandom_range(9) < 7);
		end
	endtask

	task automatic nested_calls();
		logic [31:0] calls [$];
		int depth;
		cur_test = "ras_nesting";
		repeat (20)
		begin
			depth = $urandom_range(10, 1);
			repeat (depth)
			begin
				tick();
				calls.push_back(32'h0000_8000 + ($urandom_range(1023) << 2));
				drive_jump(1'b0, calls[$], REG_RA, 5'd0);
			end
			repeat (depth)
			begin
				tick();
				drive_jump(1'b1, random_pc(), 5'd0, REG_RA);
				tick();
				check_target(cur_test, calls.pop_back() + 32'd4, jalr_pred_target);
			end
		end
	endtask

	task automatic stack_limits();
		logic [31:0] pushed [20];
		cur_test = "ras_limits";
		for (int i = 0; i < 20; i++)
		begin
			tick();
			pushed[i] = 32'h0001_0000 + 32'(i * 8);
			drive_jump(1'b0, pushed[i], REG_RA, 5'd0);
		end
		for (int j = 0; j < 20; j++)
		begin
			tick();
			drive_jump(1'b1, random_pc(), 5'd0, REG_RA);
			tick();
			check_valid(cur_test, 1'b1, jalr_pred_valid);
			check_target(cur_test, (j < 16) ? pushed[19 - j] + 32'd4 : 32'd0, jalr_pred_target);
		end
	endtask

	// Jumps that do not touch the stack must still strobe correctly
	task automatic jump_strobes();
		cur_test = "valid_strobes";
		repeat (40)
		begin
			tick();
			if (1'($urandom_range(1)))
				drive_predict(random_pc(), random_kind(), 1'($urandom_range(1)));
			case ($urandom_range(4))
				0: drive_jump(1'b0, random_pc(), REG_RA, 5'd0);
				1: drive_jump(1'b0, random_pc(), 5'd0, 5'd0);
				2: drive_jump(1'b1, random_pc(), 5'd5, 5'd7);
				3: drive_jump(1'b1, random_pc(), REG_RA, REG_RA);
				default: drive_jump(1'b1, random_pc(), 5'd0, REG_RA);
			endcase
		end
		tick();
	endtask

	initial
	begin
		void'($urandom(32'he31e));
		clk = 1'b0;
		rst_n = 1'b0;
		predict_valid = 1'b0;
		predict_pc = 32'd0;
		predict_kind = BR_BEQ;
		predict_imm_sign = 1'b0;
		resolve_valid = 1'b0;
		resolve_pc = 32'd0;
		resolve_kind = BR_BEQ;
		resolve_imm_sign = 1'b0;
		resolve_taken = 1'b0;
		jump_valid = 1'b0;
		jump_is_jalr = 1'b0;
		jump_pc = 32'd0;
		jump_rd = 5'd0;
		jump_rs1 = 5'd0;
		foreach (pc_pool[i])
			pc_pool[i] = 32'h0000_2000 + ($urandom_range(63) << 2);
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		reset_predictions();
		learn_taken_loop();
		random_traffic();
		nested_calls();
		stack_limits();
		jump_strobes();
		$display("sim passed");
		$finish;
	end

endmodule
